// ==== bench/router_stim.txt ====
# T id | P in nflits dst_x dst_y base_hex exp_out | H/R out | C out count | L | E
# router at (2,2), ports local 0 east 1 north 2 west 3 south 4
T 1
P 0 1 4 2 0a1 1
P 1 1 0 2 0a2 3
P 2 1 2 4 0a3 2
P 3 1 2 0 0a4 4
P 4 1 2 2 0a5 0
P 0 1 2 2 0a6 0
P 2 1 3 5 0a7 1
E
# four flit packet against a competitor on the west output
T 2
P 1 4 0 3 100 3
P 2 4 1 1 200 3
E
# two inputs share the south output
T 3
P 1 3 2 0 300 4
P 3 3 2 1 400 4
P 1 3 2 0 310 4
P 3 3 2 0 410 4
E
# east credits held, only a buffer's worth may leave
T 4
H 1
P 0 4 5 2 500 1
P 0 2 5 2 510 1
C 1 4
R 1
E
# local credit release burst
T 5
L
E

// ==== bench/router_tb.sv ====
`timescale 1ns/1ps
`include "router_defines.svh"

module router_tb;

    localparam string STIM_FILE = "bench/router_stim.txt";
    localparam int    P         = `ROUTER_PORTS;

    logic clk = 1'b0;
    logic rst_n;
    logic local_credit_release_en;
    noc_flit_pkg::flit_chan_t chan_in  [P];
    noc_flit_pkg::flit_chan_t chan_out [P];

    logic [17:0] send_q [P][$];       // flits waiting per input
    logic [17:0] exp_q  [P][P][$];    // per output, per source input
    int tx_credit [P];
    int sent_cnt [P];
    int credit_rx [P];
    int pending [P];                  // credits owed to an output
    int gap [P];
    int cur_src [P];                  // source of the packet in flight, -1 if none
    int last_src [P];                 // source of the last packet started per output
    int held_rx [P];
    logic [P-1:0] hold;
    logic release_active;
    int errors;
    int cycles;
    int limit;

    router_two_stage #(.ROUTER_X(2), .ROUTER_Y(2)) dut0 (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .chan_in                 (chan_in),
        .chan_out                (chan_out),
        .local_credit_release_en (local_credit_release_en)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout after %0d cycles, traffic did not drain", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    // head carries destination, later flits count up from base
    function automatic logic [17:0] flit_word(input int n, input int k, input int dx,
                                              input int dy, input logic [15:0] base);
        logic [1:0] ftype;
        logic [15:0] pl;
        if (n == 1)
            ftype = 2'b11;
        else if (k == 0)
            ftype = 2'b00;
        else if (k == n - 1)
            ftype = 2'b10;
        else
            ftype = 2'b01;
        pl = (k == 0) ? {dx[2:0], dy[2:0], base[9:0]} : base + 16'(k);
        return {ftype, pl};
    endfunction

    // another input still has flits due on this output
    function automatic bit other_waiting(input int o, input int src);
        for (int j = 0; j < P; j++)
            if (j != src && exp_q[o][j].size() > 0)
                return 1'b1;
        return 1'b0;
    endfunction

    // send side, one flit per input per cycle
    always @(posedge clk) begin
        #5;
        for (int i = 0; i < P; i++) begin
            chan_in[i].flit_wr = 1'b0;
            if (rst_n && gap[i] > 0) begin
                gap[i]--;
            end else if (rst_n && send_q[i].size() > 0 && tx_credit[i] > 0) begin
                chan_in[i].flit    = send_q[i].pop_front();
                chan_in[i].flit_wr = 1'b1;
                tx_credit[i]--;
                sent_cnt[i]++;
                if (chan_in[i].flit.ftype[1])
                    gap[i] = $urandom % 3;  // idle cycles before next packet
            end
            chan_in[i].credit = rst_n && !hold[i] && (pending[i] > 0);
            if (chan_in[i].credit)
                pending[i]--;
        end
    end

    // receive side, sampled mid-cycle
    always @(negedge clk) begin
        logic [17:0] f;
        int src;
        for (int o = 0; o < P; o++) begin
            if (rst_n && chan_out[o].credit && !release_active) begin
                tx_credit[o]++;
                credit_rx[o]++;
                if (tx_credit[o] > `BUF_DEPTH) begin
                    $display("%0t: input %0d got more credits than buffer slots", $time, o);
                    errors++;
                end
            end
            if (rst_n && chan_out[o].flit_wr) begin
                f = chan_out[o].flit;
                pending[o]++;
                held_rx[o]++;
                src = cur_src[o];
                if (src < 0) begin
                    for (int i = 0; i < P; i++)
                        if (src < 0 && exp_q[o][i].size() > 0 && exp_q[o][i][0] == f)
                            src = i;
                    if (src < 0) begin
                        $display("%0t: unexpected flit %h on output %0d", $time, f, o);
                        errors++;
                    end else begin
                        // round robin, a waiting input goes before a repeat
                        if (src == last_src[o] && other_waiting(o, src)) begin
                            $display("%0t: output %0d served input %0d twice while %s",
                                     $time, o, src, "another input waited");
                            errors++;
                        end
                        last_src[o] = src;
                    end
                end else if (exp_q[o][src].size() == 0 || exp_q[o][src][0] != f) begin
                    $display("ERR %0t chan_out[%0d].flit expected %h got %h", $time, o,
                             (exp_q[o][src].size() > 0) ? exp_q[o][src][0] : 18'h0, f);
                    errors++;
                end
                if (src >= 0 && exp_q[o][src].size() > 0)
                    void'(exp_q[o][src].pop_front());
                cur_src[o] = f[17] ? -1 : src;  // tail or single closes the packet
            end
        end
    end

    function automatic bit drained();
        for (int i = 0; i < P; i++) begin
            if (send_q[i].size() > 0 || pending[i] > 0)
                return 1'b0;
            for (int j = 0; j < P; j++)
                if (exp_q[i][j].size() > 0)
                    return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic check_release();
        logic exp_c;
        #5 local_credit_release_en = 1'b1;
        release_active = 1'b1;
        @(posedge clk);
        #5 local_credit_release_en = 1'b0;
        for (int k = 0; k < `BUF_DEPTH + 2; k++) begin
            @(negedge clk);
            exp_c = (k < `BUF_DEPTH);
            if (chan_out[0].credit !== exp_c) begin
                $display("ERR %0t chan_out[0].credit expected %b got %b", $time, exp_c,
                         chan_out[0].credit);
                errors++;
            end
        end
        release_active = 1'b0;
    endtask

    initial begin
        int fd, r, test_id, test_err, tests, in, n, dx, dy, outp, cnt, nlines;
        logic [15:0] base;
        string tok, line;
        void'($urandom(32'h898a5ecd));
        errors = 0;
        cycles = 0;
        limit = 200;
        tests = 0;
        test_id = 0;
        test_err = 0;
        hold = '0;
        release_active = 1'b0;
        local_credit_release_en = 1'b0;
        for (int i = 0; i < P; i++) begin
            chan_in[i] = '0;
            tx_credit[i] = `BUF_DEPTH;
            sent_cnt[i] = 0;
            credit_rx[i] = 0;
            pending[i] = 0;
            gap[i] = 0;
            cur_src[i] = -1;
            last_src[i] = -1;
            held_rx[i] = 0;
        end
        rst_n = 1'b0;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("cannot open %s", STIM_FILE);
            $display("Testbench failed");
            $finish;
        end
        nlines = 0;
        while (!$feof(fd)) begin
            r = $fgets(line, fd);
            nlines++;
        end
        $fclose(fd);
        limit = 20 * nlines + 200;
        repeat (4) @(posedge clk);
        #5 rst_n = 1'b1;
        fd = $fopen(STIM_FILE, "r");
        while ($fscanf(fd, "%s", tok) == 1) begin
            case (tok)
                "#": r = $fgets(line, fd);
                "T": begin
                    r = $fscanf(fd, "%d", test_id);
                    test_err = errors;
                    for (int i = 0; i < P; i++) begin
                        sent_cnt[i] = 0;
                        credit_rx[i] = 0;
                        last_src[i] = -1;
                    end
                end
                "P": begin
                    r = $fscanf(fd, "%d %d %d %d %h %d", in, n, dx, dy, base, outp);
                    for (int k = 0; k < n; k++) begin
                        send_q[in].push_back(flit_word(n, k, dx, dy, base));
                        exp_q[outp][in].push_back(flit_word(n, k, dx, dy, base));
                    end
                end
                "H": begin
                    r = $fscanf(fd, "%d", outp);
                    hold[outp] = 1'b1;
                    held_rx[outp] = 0;
                end
                "R": begin
                    r = $fscanf(fd, "%d", outp);
                    hold[outp] = 1'b0;
                end
                "C": begin
                    r = $fscanf(fd, "%d %d", outp, cnt);
                    repeat (30) @(posedge clk);
                    if (held_rx[outp] != cnt) begin
                        $display("ERR %0t flits_on_hold[%0d] expected %0d got %0d", $time,
                                 outp, cnt, held_rx[outp]);
                        errors++;
                    end
                end
                "L": check_release();
                "E": begin
                    while (!drained())
                        @(posedge clk);
                    repeat (4) @(posedge clk);
                    for (int i = 0; i < P; i++)
                        if (credit_rx[i] != sent_cnt[i]) begin
                            $display("ERR %0t credit_count[%0d] expected %0d got %0d",
                                     $time, i, sent_cnt[i], credit_rx[i]);
                            errors++;
                        end
                    tests++;
                    $display("test %0d %s", test_id, (errors == test_err) ? "ok" : "FAILED");
                end
                default: begin
                    $display("bad stimulus command %s", tok);
                    errors++;
                end
            endcase
        end
        $fclose(fd);
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// ==== common/noc_flit_pkg.sv ====
`include "router_defines.svh"

package noc_flit_pkg;

    typedef enum logic [1:0] {
        FLIT_HEAD   = 2'b00,
        FLIT_BODY   = 2'b01,
        FLIT_TAIL   = 2'b10,
        FLIT_SINGLE = 2'b11  // head and tail in one
    } flit_type_e;

    // head word: destination on top, the rest is data
    typedef struct packed {
        logic [`COORD_W-1:0]                  dst_x;
        logic [`COORD_W-1:0]                  dst_y;
        logic [`FLIT_DATA_W-2*`COORD_W-1:0]   data;
    } head_fields_t;

    // same 16 bits, routing info in head flits, plain data otherwise
    typedef union packed {
        head_fields_t              head;
        logic [`FLIT_DATA_W-1:0]   data;
    } flit_payload_u;

    typedef struct packed {
        flit_type_e      ftype;
        flit_payload_u   payload;
    } flit_t;

    // one link direction
    typedef struct packed {
        flit_t   flit;
        logic    flit_wr;   // flit valid this cycle
        logic    credit;    // flows against the flit, one slot freed
    } flit_chan_t;

endpackage

// ==== common/router_ctrl_pkg.sv ====
`include "router_defines.svh"

package router_ctrl_pkg;

    typedef enum logic [2:0] {
        PORT_LOCAL = 3'd0,
        PORT_EAST  = 3'd1,
        PORT_NORTH = 3'd2,
        PORT_WEST  = 3'd3,
        PORT_SOUTH = 3'd4
    } port_e;

    // bit n stands for port n
    typedef logic [`ROUTER_PORTS-1:0] port_onehot_t;

    // request from one input to the allocator
    typedef struct packed {
        logic           valid;
        port_onehot_t   dst;
        logic           is_tail;  // tail or single, ends the packet
    } route_req_t;

    // downstream buffer space and release burst counting
    typedef logic [`CRDT_W-1:0] crdt_cnt_t;

endpackage

// ==== common/router_defines.svh ====
`ifndef ROUTER_DEFINES_SVH
`define ROUTER_DEFINES_SVH

// local, east, north, west, south
`define ROUTER_PORTS 5

// payload bits per flit, flit type comes on top
`define FLIT_DATA_W 16

// mesh coordinate width, up to 8x8
`define COORD_W 3

// flits per input buffer
// also the start value of every output credit counter
// and the number of pulses in one credit release burst
`define BUF_DEPTH 4

// wide enough to hold BUF_DEPTH
`define CRDT_W 3

`endif

// ==== input_port/flit_fifo.sv ====
`timescale 1ns/1ps
`include "router_defines.svh"

module flit_fifo (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wr,
    input  noc_flit_pkg::flit_t   wr_flit,
    input  logic                  rd,
    output noc_flit_pkg::flit_t   head_flit,
    output logic                  empty,
    output logic                  full
);

    localparam int PTR_W = $clog2(`BUF_DEPTH);
    localparam int CNT_W = $clog2(`BUF_DEPTH + 1);

    noc_flit_pkg::flit_t mem [`BUF_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // wrap at BUF_DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(`BUF_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (wr)
            mem[wr_ptr] <= wr_flit;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr)
                wr_ptr <= ptr_next(wr_ptr);
            if (rd)
                rd_ptr <= ptr_next(rd_ptr);
            case ({wr, rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // idle or pass-through
            endcase
        end
    end

    assign head_flit = mem[rd_ptr];  // no read latency
    assign empty     = (count == '0);
    assign full      = (count == CNT_W'(`BUF_DEPTH));

    // upstream sender must respect its credits
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        !(wr && full && !rd))
        else $error("flit_fifo: write while full");

endmodule

// ==== input_port/input_port.sv ====
`timescale 1ns/1ps
`include "router_defines.svh"

module input_port #(
    parameter int ROUTER_X = 0,
    parameter int ROUTER_Y = 0
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  noc_flit_pkg::flit_chan_t       chan_in,
    input  logic                           grant,
    output router_ctrl_pkg::route_req_t    route_req,
    output noc_flit_pkg::flit_t            flit_q,
    output logic                           credit
);

    localparam logic [`COORD_W-1:0] MY_X = ROUTER_X[`COORD_W-1:0];
    localparam logic [`COORD_W-1:0] MY_Y = ROUTER_Y[`COORD_W-1:0];

    noc_flit_pkg::flit_t           head_flit;
    noc_flit_pkg::head_fields_t    hdr;
    logic                          fifo_empty;
    logic                          starts_pkt;
    logic                          ends_pkt;
    router_ctrl_pkg::port_onehot_t xy_dst;
    router_ctrl_pkg::port_onehot_t held_dst;  // route of the packet in flight

    flit_fifo u_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr        (chan_in.flit_wr),
        .wr_flit   (chan_in.flit),
        .rd        (grant),
        .head_flit (head_flit),
        .empty     (fifo_empty),
        .full      ()
    );

    assign hdr        = head_flit.payload.head;
    assign starts_pkt = (head_flit.ftype == noc_flit_pkg::FLIT_HEAD) ||
                        (head_flit.ftype == noc_flit_pkg::FLIT_SINGLE);
    assign ends_pkt   = (head_flit.ftype == noc_flit_pkg::FLIT_TAIL) ||
                        (head_flit.ftype == noc_flit_pkg::FLIT_SINGLE);

    // XY routing, x first
    always_comb begin
        xy_dst = '0;
        if (hdr.dst_x > MY_X)
            xy_dst[router_ctrl_pkg::PORT_EAST] = 1'b1;
        else if (hdr.dst_x < MY_X)
            xy_dst[router_ctrl_pkg::PORT_WEST] = 1'b1;
        else if (hdr.dst_y > MY_Y)
            xy_dst[router_ctrl_pkg::PORT_NORTH] = 1'b1;
        else if (hdr.dst_y < MY_Y)
            xy_dst[router_ctrl_pkg::PORT_SOUTH] = 1'b1;
        else
            xy_dst[router_ctrl_pkg::PORT_LOCAL] = 1'b1;
    end

    always_comb begin
        route_req.valid   = !fifo_empty;
        route_req.dst     = starts_pkt ? xy_dst : held_dst;
        route_req.is_tail = ends_pkt;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held_dst <= '0;
            credit   <= 1'b0;
        end else begin
            credit <= grant;  // popped flit frees one slot upstream
            if (grant && starts_pkt)
                held_dst <= xy_dst;
        end
    end

    // stage-one register, read by the crossbar
    always_ff @(posedge clk) begin
        if (grant)
            flit_q <= head_flit;
    end

endmodule

// ==== logic/credit_release_gen.sv ====
`timescale 1ns/1ps
`include "router_defines.svh"

module credit_release_gen (
    input  logic clk,
    input  logic rst_n,
    input  logic en,
    output logic credit
);

    router_ctrl_pkg::crdt_cnt_t cnt_q;
    logic cnt_idle;
    logic cnt_last;

    assign cnt_idle = (cnt_q == '0);
    assign cnt_last = (cnt_q == router_ctrl_pkg::crdt_cnt_t'(`BUF_DEPTH));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q  <= '0;
            credit <= 1'b0;
        end else if (cnt_last) begin
            cnt_q  <= '0;  // burst done, ready for the next enable
            credit <= 1'b0;
        end else if (en || !cnt_idle) begin
            // enable mid-burst has no effect
            cnt_q  <= cnt_q + 1'b1;
            credit <= 1'b1;
        end else begin
            credit <= 1'b0;
        end
    end

endmodule

// ==== logic/crossbar.sv ====
`timescale 1ns/1ps
`include "router_defines.svh"

module crossbar (
    input  logic                           clk,
    input  logic                           rst_n,
    input  noc_flit_pkg::flit_t            flit_q [`ROUTER_PORTS],
    input  router_ctrl_pkg::port_onehot_t  sel_q [`ROUTER_PORTS],
    input  router_ctrl_pkg::port_onehot_t  sel_valid_q,
    output noc_flit_pkg::flit_t            chan_out_flit [`ROUTER_PORTS],
    output router_ctrl_pkg::port_onehot_t  flit_wr
);

    localparam int P = `ROUTER_PORTS;

    noc_flit_pkg::flit_t           mux_flit [P];
    router_ctrl_pkg::port_onehot_t taken_by [P];  // per input, outputs reading it

    always_comb begin
        for (int o = 0; o < P; o++) begin
            mux_flit[o] = '0;
            for (int i = 0; i < P; i++) begin
                if (sel_q[o][i])
                    mux_flit[o] = flit_q[i];
                taken_by[i][o] = sel_q[o][i];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            flit_wr <= '0;
        else
            flit_wr <= sel_valid_q;
    end

    always_ff @(posedge clk) begin
        for (int o = 0; o < P; o++) begin
            if (sel_valid_q[o])
                chan_out_flit[o] <= mux_flit[o];
        end
    end

    for (genvar i = 0; i < P; i++) begin : g_chk
        a_no_fanout: assert property (@(posedge clk) disable iff (!rst_n)
            $onehot0(taken_by[i]))
            else $error("crossbar: input %0d switched to two outputs", i);
    end

endmodule

// ==== logic/router_two_stage.sv ====
`timescale 1ns/1ps
`include "router_defines.svh"

module router_two_stage #(
    parameter int ROUTER_X = 0,
    parameter int ROUTER_Y = 0
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  noc_flit_pkg::flit_chan_t  chan_in  [`ROUTER_PORTS],
    output noc_flit_pkg::flit_chan_t  chan_out [`ROUTER_PORTS],
    input  logic                      local_credit_release_en
);

    localparam int P = `ROUTER_PORTS;

    router_ctrl_pkg::route_req_t   route_req [P];
    router_ctrl_pkg::port_onehot_t grant;
    router_ctrl_pkg::port_onehot_t sel_q [P];
    router_ctrl_pkg::port_onehot_t sel_valid_q;
    noc_flit_pkg::flit_t           flit_q [P];     // stage-one registers
    noc_flit_pkg::flit_t           xbar_flit [P];
    router_ctrl_pkg::port_onehot_t xbar_wr;
    logic [P-1:0]                  port_credit;    // to upstream senders
    logic [P-1:0]                  credit_in;      // from downstream receivers
    logic                          release_credit;

    for (genvar i = 0; i < P; i++) begin : g_port
        input_port #(
            .ROUTER_X (ROUTER_X),
            .ROUTER_Y (ROUTER_Y)
        ) u_input_port (
            .clk       (clk),
            .rst_n     (rst_n),
            .chan_in   (chan_in[i]),
            .grant     (grant[i]),
            .route_req (route_req[i]),
            .flit_q    (flit_q[i]),
            .credit    (port_credit[i])
        );
    end

    switch_alloc u_switch_alloc (
        .clk         (clk),
        .rst_n       (rst_n),
        .route_req   (route_req),
        .credit_in   (credit_in),
        .grant       (grant),
        .sel_q       (sel_q),
        .sel_valid_q (sel_valid_q)
    );

    crossbar u_crossbar (
        .clk           (clk),
        .rst_n         (rst_n),
        .flit_q        (flit_q),
        .sel_q         (sel_q),
        .sel_valid_q   (sel_valid_q),
        .chan_out_flit (xbar_flit),
        .flit_wr       (xbar_wr)
    );

    // lets a restarted local endpoint relearn its credits
    credit_release_gen u_credit_release (
        .clk    (clk),
        .rst_n  (rst_n),
        .en     (local_credit_release_en),
        .credit (release_credit)
    );

    always_comb begin
        for (int i = 0; i < P; i++) begin
            credit_in[i]        = chan_in[i].credit;
            chan_out[i].flit    = xbar_flit[i];
            chan_out[i].flit_wr = xbar_wr[i];
            chan_out[i].credit  = port_credit[i] |
                                  ((i == router_ctrl_pkg::PORT_LOCAL) && release_credit);
        end
    end

endmodule

// ==== logic/switch_alloc.sv ====
`timescale 1ns/1ps
`include "router_defines.svh"

module switch_alloc (
    input  logic                           clk,
    input  logic                           rst_n,
    input  router_ctrl_pkg::route_req_t    route_req [`ROUTER_PORTS],
    input  logic [`ROUTER_PORTS-1:0]       credit_in,
    output router_ctrl_pkg::port_onehot_t  grant,
    output router_ctrl_pkg::port_onehot_t  sel_q [`ROUTER_PORTS],
    output router_ctrl_pkg::port_onehot_t  sel_valid_q
);

    localparam int P     = `ROUTER_PORTS;
    localparam int PTR_W = $clog2(`ROUTER_PORTS);

    router_ctrl_pkg::port_onehot_t out_gnt [P];       // per output, bit per input
    router_ctrl_pkg::port_onehot_t gnt_by_in [P];     // per input, bit per output
    router_ctrl_pkg::port_onehot_t lock_owner_q [P];
    router_ctrl_pkg::crdt_cnt_t    crdt_q [P];
    logic [P-1:0]                  lock_q;
    logic [PTR_W-1:0]              ptr_q [P];          // highest priority input
    logic [PTR_W-1:0]              winner [P];
    logic [P-1:0]                  out_tail;

    always_comb begin
        router_ctrl_pkg::port_onehot_t req;
        int idx;
        for (int o = 0; o < P; o++) begin
            for (int i = 0; i < P; i++)
                req[i] = route_req[i].valid & route_req[i].dst[o];
            if (lock_q[o])
                req = req & lock_owner_q[o];  // wormhole, owner only
            if (crdt_q[o] == '0)
                req = '0;
            out_gnt[o] = '0;
            winner[o]  = '0;
            for (int k = 0; k < P; k++) begin
                idx = int'(ptr_q[o]) + k;
                if (idx >= P)
                    idx = idx - P;
                if (req[idx] && (out_gnt[o] == '0)) begin
                    out_gnt[o][idx] = 1'b1;
                    winner[o]       = PTR_W'(idx);
                end
            end
            out_tail[o] = route_req[winner[o]].is_tail;
        end
    end

    always_comb begin
        for (int i = 0; i < P; i++) begin
            for (int o = 0; o < P; o++)
                gnt_by_in[i][o] = out_gnt[o][i];
            grant[i] = |gnt_by_in[i];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int o = 0; o < P; o++) begin
                sel_q[o]        <= '0;
                lock_owner_q[o] <= '0;
                crdt_q[o]       <= `BUF_DEPTH;
                ptr_q[o]        <= '0;
            end
            lock_q      <= '0;
            sel_valid_q <= '0;
        end else begin
            for (int o = 0; o < P; o++) begin
                sel_q[o]       <= out_gnt[o];
                sel_valid_q[o] <= |out_gnt[o];
                crdt_q[o] <= crdt_q[o]
                             + router_ctrl_pkg::crdt_cnt_t'(credit_in[o])
                             - router_ctrl_pkg::crdt_cnt_t'(|out_gnt[o]);
                if (|out_gnt[o]) begin
                    if (out_tail[o]) begin
                        lock_q[o] <= 1'b0;
                        ptr_q[o]  <= (winner[o] == PTR_W'(P - 1)) ? '0 : winner[o] + 1'b1;
                    end else begin
                        lock_q[o]       <= 1'b1;
                        lock_owner_q[o] <= out_gnt[o];
                    end
                end
            end
        end
    end

    for (genvar o = 0; o < P; o++) begin : g_out_chk
        a_sel_onehot: assert property (@(posedge clk) disable iff (!rst_n)
            $onehot0(sel_q[o]));
        // downstream returned more credits than it has slots
        a_crdt_max: assert property (@(posedge clk) disable iff (!rst_n)
            crdt_q[o] <= `BUF_DEPTH);
    end

    for (genvar i = 0; i < P; i++) begin : g_in_chk
        a_one_output: assert property (@(posedge clk) disable iff (!rst_n)
            $onehot0(gnt_by_in[i]));
    end

endmodule

// ==== router_two_stage.f ====
+incdir+common
common/noc_flit_pkg.sv
common/router_ctrl_pkg.sv
input_port/flit_fifo.sv
input_port/input_port.sv
logic/switch_alloc.sv
logic/crossbar.sv
logic/credit_release_gen.sv
logic/router_two_stage.sv
bench/router_tb.sv
